//--- eeprom_subsystem.f
+incdir+rtl
rtl/eeprom_pkg.sv
rtl/apb_eeprom_regs.sv
rtl/i2c_txn_sequencer.sv
rtl/i2c_bit_engine.sv
rtl/eeprom_slave.sv
rtl/eeprom_subsystem.sv
verification/tb_eeprom_subsystem.sv

//--- rtl/apb_eeprom_regs.sv
`timescale 1ns/1ps
`include "eeprom_config.svh"

module apb_eeprom_regs (
    input  logic                  sda,
    input  logic                  rst_n,
    input  eeprom_pkg::apb_addr_t paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  txn_start,
    output logic                  txn_read,
    output eeprom_pkg::mem_addr_t txn_addr,
    output eeprom_pkg::byte_t     txn_wdata,
    input  logic                  txn_done,
    input  eeprom_pkg::byte_t     txn_rdata
);

    logic                  access;
    logic                  wr_en;
    logic                  busy;
    logic                  locked;
    logic                  start_req;
    eeprom_pkg::mem_addr_t addr_q;
    eeprom_pkg::byte_t     wdata_q;
    eeprom_pkg::byte_t     rdata_q;

    assign access = psel && penable;
    assign wr_en  = access && pwrite;

    // The start pulse cycle already counts as busy
    assign locked    = busy || txn_start;
    assign start_req = wr_en && (paddr == `REG_CTRL) && pwdata[0] && !locked;

    assign txn_addr  = addr_q;
    assign txn_wdata = wdata_q;

    always_ff @(posedge sda or negedge rst_n)
    begin
        if (!rst_n)
        begin
            busy      <= 1'b0;
            txn_start <= 1'b0;
            txn_read  <= 1'b0;
        end
        else
        begin
            txn_start <= start_req;
            if (start_req)
            begin
                txn_read <= pwdata[1];
            end
            if (txn_start)
            begin
                busy <= 1'b1;
            end
            else if (txn_done)
            begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge sda)
    begin
        if (wr_en && !locked && paddr == `REG_ADDR)
        begin
            addr_q <= pwdata[`EEPROM_ADDR_W-1:0];
        end
        if (wr_en && !locked && paddr == `REG_WDATA)
        begin
            wdata_q <= pwdata[`EEPROM_BYTE_W-1:0];
        end
        if (txn_done && txn_read)
        begin
            rdata_q <= txn_rdata;
        end
    end

    always_comb
    begin
        prdata = '0;
        if (access && !pwrite)
        begin
            case (paddr)
                `REG_STATUS: prdata[0] = locked;
                `REG_ADDR:   prdata[`EEPROM_ADDR_W-1:0] = addr_q;
                `REG_WDATA:  prdata[`EEPROM_BYTE_W-1:0] = wdata_q;
                `REG_RDATA:  prdata[`EEPROM_BYTE_W-1:0] = rdata_q;
                default:     prdata = '0;
            endcase
        end
    end

    a_penable_in_sel: assert property (@(posedge sda) disable iff (!rst_n)
        penable |-> psel);

    // The sequencer handles one frame at a time, so done only closes an open frame
    a_done_in_frame: assert property (@(posedge sda) disable iff (!rst_n)
        txn_done |-> busy && !txn_start);

endmodule

//--- rtl/eeprom_config.svh
`ifndef EEPROM_CONFIG_SVH
`define EEPROM_CONFIG_SVH

// Data path and array geometry
`define EEPROM_BYTE_W 8
`define EEPROM_ADDR_W 11
`define EEPROM_DEPTH 2048
`define EEPROM_APB_AW 4

// Upper nibble of every device-select byte
`define EEPROM_DEV_TYPE 4'b1010

// sda cycles per quarter SCL period, at least 4 for the slave synchronizers
`define EEPROM_SCL_DIV 4

// APB register offsets, STATUS shares the CTRL offset on reads
`define REG_CTRL 4'h0
`define REG_ADDR 4'h4
`define REG_WDATA 4'h8
`define REG_RDATA 4'hC
`define REG_STATUS 4'h0

`endif

//--- rtl/eeprom_pkg.sv
`include "eeprom_config.svh"

package eeprom_pkg;

    typedef logic [`EEPROM_BYTE_W-1:0] byte_t;
    typedef logic [`EEPROM_ADDR_W-1:0] mem_addr_t;
    typedef logic [`EEPROM_APB_AW-1:0] apb_addr_t;

    // One bit-level condition on the two-wire bus
    typedef enum logic [1:0] {
        cmd_start,
        cmd_stop,
        cmd_write,
        cmd_read
    } bit_cmd_e;

    typedef enum logic [3:0] {
        seq_idle,
        seq_start,
        seq_dev,
        seq_addr,
        seq_wdata,
        seq_rstart,
        seq_rdev,
        seq_rdata,
        seq_nack,
        seq_stop,
        seq_done
    } seq_state_e;

    typedef enum logic [2:0] {
        sl_idle,
        sl_dev,
        sl_word_addr,
        sl_write_data,
        sl_read_data,
        sl_ack
    } slave_state_e;

endpackage

//--- rtl/eeprom_slave.sv
`timescale 1ns/1ps
`include "eeprom_config.svh"

module eeprom_slave (
    input  logic sda,
    input  logic rst_n,
    input  logic scl_in,
    input  logic dat_in,
    output logic dat_pull_s
);

    eeprom_pkg::slave_state_e state;
    eeprom_pkg::slave_state_e ack_from;
    eeprom_pkg::byte_t        mem [`EEPROM_DEPTH];
    eeprom_pkg::byte_t        sh;
    eeprom_pkg::byte_t        word_q;
    eeprom_pkg::byte_t        rd_byte;
    eeprom_pkg::mem_addr_t    addr;
    logic [2:0]               page_q;
    logic                     rw_q;
    logic [3:0]               cnt;
    logic [2:0]               scl_r;
    logic [2:0]               dat_r;
    logic                     scl_rise;
    logic                     scl_fall;
    logic                     start_det;
    logic                     stop_det;
    logic                     rx_state;
    logic                     byte_in;

    // Bit 1 is the synchronized line, bit 2 its previous value
    always_ff @(posedge sda or negedge rst_n)
    begin
        if (!rst_n)
        begin
            scl_r <= 3'b111;
            dat_r <= 3'b111;
        end
        else
        begin
            scl_r <= {scl_r[1:0], scl_in};
            dat_r <= {dat_r[1:0], dat_in};
        end
    end

    assign scl_rise  = scl_r[1] && !scl_r[2];
    assign scl_fall  = !scl_r[1] && scl_r[2];
    assign start_det = scl_r[1] && scl_r[2] && dat_r[2] && !dat_r[1];
    assign stop_det  = scl_r[1] && scl_r[2] && !dat_r[2] && dat_r[1];

    assign rx_state = state == eeprom_pkg::sl_dev || state == eeprom_pkg::sl_word_addr
                      || state == eeprom_pkg::sl_write_data;
    assign byte_in  = scl_fall && cnt == 4'd8;
    assign addr     = {page_q, word_q};
    assign rd_byte  = mem[addr];

    always_ff @(posedge sda or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state      <= eeprom_pkg::sl_idle;
            ack_from   <= eeprom_pkg::sl_idle;
            rw_q       <= 1'b0;
            cnt        <= 4'd0;
            dat_pull_s <= 1'b0;
        end
        else if (start_det)
        begin
            state      <= eeprom_pkg::sl_dev;
            cnt        <= 4'd0;
            dat_pull_s <= 1'b0;
        end
        else if (stop_det)
        begin
            state      <= eeprom_pkg::sl_idle;
            dat_pull_s <= 1'b0;
        end
        else
        begin
            case (state)
                eeprom_pkg::sl_dev, eeprom_pkg::sl_word_addr, eeprom_pkg::sl_write_data:
                    if (scl_rise && cnt < 4'd8)
                    begin
                        cnt <= cnt + 4'd1;
                    end
                    else if (byte_in)
                    begin
                        cnt <= 4'd0;
                        // A foreign device type is left unacknowledged
                        if (state == eeprom_pkg::sl_dev && sh[7:4] != `EEPROM_DEV_TYPE)
                        begin
                            state <= eeprom_pkg::sl_idle;
                        end
                        else
                        begin
                            dat_pull_s <= 1'b1;
                            ack_from   <= state;
                            state      <= eeprom_pkg::sl_ack;
                            if (state == eeprom_pkg::sl_dev)
                            begin
                                rw_q <= sh[0];
                            end
                        end
                    end
                eeprom_pkg::sl_read_data:
                    if (scl_fall)
                    begin
                        if (cnt == 4'd7)
                        begin
                            dat_pull_s <= 1'b0;
                            ack_from   <= eeprom_pkg::sl_read_data;
                            state      <= eeprom_pkg::sl_ack;
                            cnt        <= 4'd0;
                        end
                        else
                        begin
                            dat_pull_s <= !sh[`EEPROM_BYTE_W-2];
                            cnt        <= cnt + 4'd1;
                        end
                    end
                eeprom_pkg::sl_ack:
                    if (ack_from == eeprom_pkg::sl_read_data)
                    begin
                        // Master acknowledge clock, no sequential reads follow
                        if (scl_rise)
                        begin
                            state <= eeprom_pkg::sl_idle;
                        end
                    end
                    else if (scl_fall)
                    begin
                        dat_pull_s <= 1'b0;
                        case (ack_from)
                            eeprom_pkg::sl_dev:
                                if (rw_q)
                                begin
                                    state      <= eeprom_pkg::sl_read_data;
                                    dat_pull_s <= !rd_byte[`EEPROM_BYTE_W-1];
                                end
                                else
                                begin
                                    state <= eeprom_pkg::sl_word_addr;
                                end
                            eeprom_pkg::sl_word_addr: state <= eeprom_pkg::sl_write_data;
                            default:                  state <= eeprom_pkg::sl_idle;
                        endcase
                    end
                default:
                    cnt <= 4'd0;
            endcase
        end
    end

    always_ff @(posedge sda)
    begin
        if (rx_state && scl_rise && cnt < 4'd8)
        begin
            sh <= {sh[`EEPROM_BYTE_W-2:0], dat_r[1]};
        end
        else if (state == eeprom_pkg::sl_ack && ack_from == eeprom_pkg::sl_dev
                 && scl_fall && rw_q)
        begin
            sh <= rd_byte;
        end
        else if (state == eeprom_pkg::sl_read_data && scl_fall)
        begin
            sh <= sh << 1;
        end
        if (state == eeprom_pkg::sl_dev && byte_in)
        begin
            page_q <= sh[3:1];
        end
        if (state == eeprom_pkg::sl_word_addr && byte_in)
        begin
            word_q <= sh;
        end
        // The data byte lands in the array as its acknowledge starts
        if (state == eeprom_pkg::sl_write_data && byte_in)
        begin
            mem[addr] <= sh;
        end
    end

endmodule

//--- rtl/eeprom_subsystem.sv
`timescale 1ns/1ps

module eeprom_subsystem (
    input  logic                  sda,
    input  logic                  rst_n,
    input  eeprom_pkg::apb_addr_t paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  scl
);

    logic                  txn_start;
    logic                  txn_read;
    logic                  txn_done;
    eeprom_pkg::mem_addr_t txn_addr;
    eeprom_pkg::byte_t     txn_wdata;
    eeprom_pkg::byte_t     txn_rdata;
    logic                  bit_cmd_valid;
    eeprom_pkg::bit_cmd_e  bit_cmd;
    logic                  bit_wdata;
    logic                  bit_done;
    logic                  bit_rdata;
    logic                  scl_pull;
    logic                  dat_pull_m;
    logic                  dat_pull_s;
    logic                  i2c_dat;

    // Pull-ups on both wires, any pull enable drives the line low
    assign scl     = ~scl_pull;
    assign i2c_dat = ~(dat_pull_m | dat_pull_s);

    apb_eeprom_regs u_regs (
        .sda       (sda),
        .rst_n     (rst_n),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .txn_start (txn_start),
        .txn_read  (txn_read),
        .txn_addr  (txn_addr),
        .txn_wdata (txn_wdata),
        .txn_done  (txn_done),
        .txn_rdata (txn_rdata)
    );

    i2c_txn_sequencer u_seq (
        .sda           (sda),
        .rst_n         (rst_n),
        .txn_start     (txn_start),
        .txn_read      (txn_read),
        .txn_addr      (txn_addr),
        .txn_wdata     (txn_wdata),
        .txn_done      (txn_done),
        .txn_rdata     (txn_rdata),
        .bit_cmd_valid (bit_cmd_valid),
        .bit_cmd       (bit_cmd),
        .bit_wdata     (bit_wdata),
        .bit_done      (bit_done),
        .bit_rdata     (bit_rdata)
    );

    i2c_bit_engine u_bit (
        .sda           (sda),
        .rst_n         (rst_n),
        .bit_cmd_valid (bit_cmd_valid),
        .bit_cmd       (bit_cmd),
        .bit_wdata     (bit_wdata),
        .bit_done      (bit_done),
        .bit_rdata     (bit_rdata),
        .scl_pull      (scl_pull),
        .dat_pull_m    (dat_pull_m),
        .dat_in        (i2c_dat)
    );

    eeprom_slave u_slave (
        .sda        (sda),
        .rst_n      (rst_n),
        .scl_in     (scl),
        .dat_in     (i2c_dat),
        .dat_pull_s (dat_pull_s)
    );

endmodule

//--- rtl/i2c_bit_engine.sv
`timescale 1ns/1ps
`include "eeprom_config.svh"

module i2c_bit_engine (
    input  logic                 sda,
    input  logic                 rst_n,
    input  logic                 bit_cmd_valid,
    input  eeprom_pkg::bit_cmd_e bit_cmd,
    input  logic                 bit_wdata,
    output logic                 bit_done,
    output logic                 bit_rdata,
    output logic                 scl_pull,
    output logic                 dat_pull_m,
    input  logic                 dat_in
);

    localparam int QW = $clog2(`EEPROM_SCL_DIV);

    logic [QW-1:0] qcnt;
    logic [1:0]    phase;
    logic          q_last;
    logic          scl_nxt;
    logic          dat_nxt;

    assign q_last   = qcnt == QW'(`EEPROM_SCL_DIV - 1);
    assign bit_done = bit_cmd_valid && q_last && phase == 2'd3;

    // Phases 0 and 3 hold SCL low for data bits, start and stop shape their own edges
    always_comb
    begin
        scl_nxt = 1'b0;
        dat_nxt = 1'b0;
        if (bit_cmd_valid)
        begin
            case (bit_cmd)
                eeprom_pkg::cmd_start:
                begin
                    scl_nxt = phase == 2'd0 || phase == 2'd3;
                    dat_nxt = phase[1];
                end
                eeprom_pkg::cmd_stop:
                begin
                    scl_nxt = phase == 2'd0;
                    dat_nxt = !phase[1];
                end
                eeprom_pkg::cmd_write:
                begin
                    scl_nxt = phase == 2'd0 || phase == 2'd3;
                    dat_nxt = !bit_wdata;
                end
                default:
                    scl_nxt = phase == 2'd0 || phase == 2'd3;
            endcase
        end
    end

    always_ff @(posedge sda or negedge rst_n)
    begin
        if (!rst_n)
        begin
            qcnt       <= '0;
            phase      <= 2'd0;
            scl_pull   <= 1'b0;
            dat_pull_m <= 1'b0;
        end
        else
        begin
            scl_pull   <= scl_nxt;
            dat_pull_m <= dat_nxt;
            if (!bit_cmd_valid)
            begin
                qcnt  <= '0;
                phase <= 2'd0;
            end
            else if (q_last)
            begin
                qcnt  <= '0;
                phase <= phase + 2'd1;
            end
            else
            begin
                qcnt <= qcnt + QW'(1);
            end
        end
    end

    // Sample in the middle of SCL high
    always_ff @(posedge sda)
    begin
        if (bit_cmd_valid && phase == 2'd1 && q_last)
        begin
            bit_rdata <= dat_in;
        end
    end

    a_dat_stable_scl_high: assert property (@(posedge sda) disable iff (!rst_n)
        $changed(dat_pull_m) && !scl_pull && !$past(scl_pull) |->
            $past(bit_cmd) inside {eeprom_pkg::cmd_start, eeprom_pkg::cmd_stop});

endmodule

//--- rtl/i2c_txn_sequencer.sv
`timescale 1ns/1ps
`include "eeprom_config.svh"

module i2c_txn_sequencer (
    input  logic                  sda,
    input  logic                  rst_n,
    input  logic                  txn_start,
    input  logic                  txn_read,
    input  eeprom_pkg::mem_addr_t txn_addr,
    input  eeprom_pkg::byte_t     txn_wdata,
    output logic                  txn_done,
    output eeprom_pkg::byte_t     txn_rdata,
    output logic                  bit_cmd_valid,
    output eeprom_pkg::bit_cmd_e  bit_cmd,
    output logic                  bit_wdata,
    input  logic                  bit_done,
    input  logic                  bit_rdata
);

    eeprom_pkg::seq_state_e state;
    eeprom_pkg::byte_t      sh;
    logic [3:0]             cnt;
    logic                   byte_end;

    // Bit 8 of every outgoing byte is the slave acknowledge
    assign byte_end  = bit_done && cnt == 4'd8;
    assign txn_rdata = sh;

    always_ff @(posedge sda or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state         <= eeprom_pkg::seq_idle;
            cnt           <= 4'd0;
            bit_cmd_valid <= 1'b0;
            txn_done      <= 1'b0;
        end
        else
        begin
            txn_done <= 1'b0;
            case (state)
                eeprom_pkg::seq_idle:
                    if (txn_start)
                    begin
                        state         <= eeprom_pkg::seq_start;
                        bit_cmd_valid <= 1'b1;
                    end
                eeprom_pkg::seq_start:
                    if (bit_done)
                    begin
                        state <= eeprom_pkg::seq_dev;
                        cnt   <= 4'd0;
                    end
                eeprom_pkg::seq_dev, eeprom_pkg::seq_addr,
                eeprom_pkg::seq_wdata, eeprom_pkg::seq_rdev:
                    if (byte_end)
                    begin
                        cnt <= 4'd0;
                        case (state)
                            eeprom_pkg::seq_dev:  state <= eeprom_pkg::seq_addr;
                            eeprom_pkg::seq_addr: state <= txn_read ? eeprom_pkg::seq_rstart
                                                                    : eeprom_pkg::seq_wdata;
                            eeprom_pkg::seq_rdev: state <= eeprom_pkg::seq_rdata;
                            default:              state <= eeprom_pkg::seq_stop;
                        endcase
                    end
                    else if (bit_done)
                    begin
                        cnt <= cnt + 4'd1;
                    end
                eeprom_pkg::seq_rstart:
                    if (bit_done)
                    begin
                        state <= eeprom_pkg::seq_rdev;
                    end
                eeprom_pkg::seq_rdata:
                    if (bit_done)
                    begin
                        cnt <= cnt + 4'd1;
                        if (cnt == 4'd7)
                        begin
                            state <= eeprom_pkg::seq_nack;
                        end
                    end
                eeprom_pkg::seq_nack:
                    if (bit_done)
                    begin
                        state <= eeprom_pkg::seq_stop;
                    end
                eeprom_pkg::seq_stop:
                    if (bit_done)
                    begin
                        state         <= eeprom_pkg::seq_done;
                        bit_cmd_valid <= 1'b0;
                    end
                default:
                begin
                    txn_done <= 1'b1;
                    state    <= eeprom_pkg::seq_idle;
                end
            endcase
        end
    end

    // Outgoing bytes leave MSB first, the read byte enters at the LSB
    always_ff @(posedge sda)
    begin
        if (state == eeprom_pkg::seq_idle && txn_start)
        begin
            sh <= {`EEPROM_DEV_TYPE, txn_addr[`EEPROM_ADDR_W-1 -: 3], 1'b0};
        end
        else if (bit_done)
        begin
            case (state)
                eeprom_pkg::seq_dev:
                    sh <= (cnt == 4'd8) ? txn_addr[`EEPROM_BYTE_W-1:0] : sh << 1;
                eeprom_pkg::seq_addr:
                    sh <= (cnt == 4'd8) ? txn_wdata : sh << 1;
                eeprom_pkg::seq_wdata, eeprom_pkg::seq_rdev:
                    sh <= sh << 1;
                eeprom_pkg::seq_rstart:
                    sh <= {`EEPROM_DEV_TYPE, txn_addr[`EEPROM_ADDR_W-1 -: 3], 1'b1};
                eeprom_pkg::seq_rdata:
                    sh <= {sh[`EEPROM_BYTE_W-2:0], bit_rdata};
                default:
                    sh <= sh;
            endcase
        end
    end

    always_comb
    begin
        bit_cmd   = eeprom_pkg::cmd_write;
        bit_wdata = 1'b1;
        case (state)
            eeprom_pkg::seq_start, eeprom_pkg::seq_rstart:
                bit_cmd = eeprom_pkg::cmd_start;
            eeprom_pkg::seq_stop:
                bit_cmd = eeprom_pkg::cmd_stop;
            eeprom_pkg::seq_dev, eeprom_pkg::seq_addr,
            eeprom_pkg::seq_wdata, eeprom_pkg::seq_rdev:
                if (cnt == 4'd8)
                begin
                    bit_cmd = eeprom_pkg::cmd_read;
                end
                else
                begin
                    bit_wdata = sh[`EEPROM_BYTE_W-1];
                end
            eeprom_pkg::seq_rdata:
                bit_cmd = eeprom_pkg::cmd_read;
            // Master NACK ends the random read
            eeprom_pkg::seq_nack:
                bit_wdata = 1'b1;
            default:
                bit_wdata = 1'b1;
        endcase
    end

    a_cmd_held: assert property (@(posedge sda) disable iff (!rst_n)
        bit_cmd_valid && !bit_done |=>
            bit_cmd_valid && $stable(bit_cmd) && $stable(bit_wdata));

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log for the fail message

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f eeprom_subsystem.f \
    --top-module tb_eeprom_subsystem \
    -o tb_sim > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1 \
    && cat sim.log \
    || { cat sim.log; echo "Simulation exited with an error"; exit 1; }

grep -qF "*** FAILED ***" sim.log && exit 1 || exit 0

//--- verification/tb_eeprom_subsystem.sv
`timescale 1ns/1ps
`include "eeprom_config.svh"

module tb_eeprom_subsystem;

    localparam int POLL_LIMIT = 1000;

    logic                  sda;
    logic                  rst_n;
    eeprom_pkg::apb_addr_t paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [31:0]           pwdata;
    logic [31:0]           prdata;
    logic                  scl;

    int unsigned seed;
    int          errors;
    int          checks;
    logic        hung;

    // Model of the array, holds every byte the testbench has written
    logic [7:0]  ref_mem [`EEPROM_DEPTH];

    eeprom_subsystem u_dut (
        .sda     (sda),
        .rst_n   (rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .scl     (scl)
    );

    always #50 sda = ~sda;

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act)
        begin
            $display("ERROR %0t %s expected 0x%0h actual 0x%0h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic apb_write(input eeprom_pkg::apb_addr_t addr, input logic [31:0] data);
        @(posedge sda);
        paddr   <= addr;
        pwrite  <= 1'b1;
        pwdata  <= data;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge sda);
        penable <= 1'b1;
        @(posedge sda);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    // prdata is sampled mid-cycle in the access phase
    task automatic apb_read(input eeprom_pkg::apb_addr_t addr, output logic [31:0] data);
        @(posedge sda);
        paddr   <= addr;
        pwrite  <= 1'b0;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge sda);
        penable <= 1'b1;
        @(negedge sda);
        data = prdata;
        @(posedge sda);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic wait_idle();
        logic [31:0] status;
        int          polls;
        polls  = 0;
        status = 32'h1;
        while (status[0] && polls < POLL_LIMIT)
        begin
            apb_read(`REG_STATUS, status);
            polls++;
        end
        if (status[0])
        begin
            $display("Timeout at %0t: STATUS busy still set after %0d polls", $time, polls);
            errors++;
            hung = 1'b1;
        end
    endtask

    task automatic write_byte(input logic [10:0] addr, input logic [7:0] data);
        apb_write(`REG_ADDR, 32'(addr));
        apb_write(`REG_WDATA, 32'(data));
        apb_write(`REG_CTRL, 32'h1);
        wait_idle();
        ref_mem[addr] = data;
    endtask

    task automatic read_byte(input logic [10:0] addr, output logic [7:0] data);
        logic [31:0] word;
        apb_write(`REG_ADDR, 32'(addr));
        apb_write(`REG_CTRL, 32'h3);
        wait_idle();
        apb_read(`REG_RDATA, word);
        data = word[7:0];
    endtask

    task automatic end_test(input string name, input int errs_before);
        $display("Test %s done with %0d errors", name, errors - errs_before);
    endtask

    task automatic test_reset_state();
        logic [31:0] status;
        int          errs_before;
        errs_before = errors;
        apb_read(`REG_STATUS, status);
        check_eq("STATUS", 32'h0, status);
        @(negedge sda);
        check_eq("scl", 32'h1, 32'(scl));
        end_test("reset_state", errs_before);
    endtask

    task automatic test_write_read();
        logic [7:0] data;
        logic [7:0] rd;
        int         errs_before;
        errs_before = errors;
        data = 8'($urandom);
        write_byte(11'h123, data);
        read_byte(11'h123, rd);
        check_eq("RDATA[0x123]", 32'(ref_mem[11'h123]), 32'(rd));
        end_test("write_read", errs_before);
    endtask

    // Same word address, different page bits in the device byte
    task automatic test_page_bits();
        logic [7:0] d_lo;
        logic [7:0] rd;
        int         errs_before;
        errs_before = errors;
        d_lo = 8'($urandom);
        write_byte(11'h0A5, d_lo);
        write_byte(11'h5A5, ~d_lo);
        read_byte(11'h0A5, rd);
        check_eq("RDATA[0x0A5]", 32'(ref_mem[11'h0A5]), 32'(rd));
        read_byte(11'h5A5, rd);
        check_eq("RDATA[0x5A5]", 32'(ref_mem[11'h5A5]), 32'(rd));
        end_test("page_bits", errs_before);
    endtask

    task automatic test_busy_lockout();
        logic [7:0]  d1;
        logic [7:0]  rd;
        logic [31:0] word;
        int          errs_before;
        errs_before = errors;
        d1 = 8'($urandom);
        apb_write(`REG_ADDR, 32'h3C7);
        apb_write(`REG_WDATA, 32'(d1));
        apb_write(`REG_CTRL, 32'h1);
        apb_read(`REG_STATUS, word);
        check_eq("STATUS busy", 32'h1, word);
        // Neither of these may reach the running frame, a read request would turn it into a read
        apb_write(`REG_WDATA, 32'(~d1));
        apb_write(`REG_CTRL, 32'h3);
        wait_idle();
        ref_mem[11'h3C7] = d1;
        apb_read(`REG_WDATA, word);
        check_eq("WDATA", 32'(d1), word);
        read_byte(11'h3C7, rd);
        check_eq("RDATA[0x3C7]", 32'(ref_mem[11'h3C7]), 32'(rd));
        end_test("busy_lockout", errs_before);
    endtask

    task automatic test_random_rw();
        logic [10:0] addrs [8];
        logic [7:0]  rd;
        int          k;
        int          errs_before;
        errs_before = errors;
        for (int i = 0; i < 8; i++)
        begin
            addrs[i] = 11'($urandom);
        end
        // A repeated address makes the later write the one to read back
        addrs[6] = addrs[1];
        for (int i = 0; i < 8; i++)
        begin
            write_byte(addrs[i], 8'($urandom));
        end
        for (int i = 0; i < 8; i++)
        begin
            k = (i * 3 + 1) % 8;
            read_byte(addrs[k], rd);
            check_eq($sformatf("RDATA[0x%03h]", addrs[k]), 32'(ref_mem[addrs[k]]), 32'(rd));
        end
        end_test("random_rw", errs_before);
    endtask

    initial
    begin
        sda     = 1'b0;
        rst_n   = 1'b0;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = 32'h0;
        errors  = 0;
        checks  = 0;
        hung    = 1'b0;
        seed    = $urandom(32'he62a);
        repeat (10) @(posedge sda);
        rst_n <= 1'b1;
        test_reset_state();
        if (!hung)
        begin
            test_write_read();
        end
        if (!hung)
        begin
            test_page_bits();
        end
        if (!hung)
        begin
            test_busy_lockout();
        end
        if (!hung)
        begin
            test_random_rw();
        end
        $display("Totals: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
        begin
            $display("*** PASSED ***");
        end
        else
        begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
